/* common/mmu_defines.svh */
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// tlb geometry
`define MMU_TLB_NUM   16
`define MMU_TLB_IDX_W 4

// exception codes
`define MMU_ECODE_NONE 6'h0
`define MMU_ECODE_PIL  6'h1
`define MMU_ECODE_PIS  6'h2
`define MMU_ECODE_PIF  6'h3
`define MMU_ECODE_PME  6'h4
`define MMU_ECODE_PPI  6'h7

// refill gets its own vector
`define MMU_ECODE_TLBR 6'h3F

`endif

/* common/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    //////////////////////////////////////////////////
    // tlb storage
    //////////////////////////////////////////////////

    // one half of an odd/even page pair
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    // page0 maps the even page, page1 the odd one
    typedef struct packed {
        logic        exist;
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic      found;
        tlb_page_t page;
    } tlb_search_t;

    //////////////////////////////////////////////////
    // control state and port payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [1:0] plv;
        logic       da;
        logic       pg;
    } crmd_t;

    // plv_en bit n allows privilege level n
    typedef struct packed {
        logic [3:0] plv_en;
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        wr;
    } xlate_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
    } xlate_rsp_t;

endpackage

`default_nettype wire

/* tlb/tlb_entry.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_entry (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire logic                we_i,
    input  wire logic                invall_i,
    input  wire mmu_pkg::tlb_entry_t wentry_i,
    input  wire logic [18:0]         s0_vppn_i,
    input  wire logic [18:0]         s1_vppn_i,
    input  wire logic [9:0]          asid_i,
    output logic                     hit0_o,
    output logic                     hit1_o,
    output mmu_pkg::tlb_entry_t      entry_o
);

    mmu_pkg::tlb_entry_t entry_q;
    logic                asid_ok;

    // invalidate only drops the exist bit, the rest stays
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            entry_q <= '0;
        end else if (invall_i) begin
            entry_q.exist <= 1'b0;
        end else if (we_i) begin
            entry_q <= wentry_i;
        end
    end

    // global pages ignore the asid
    assign asid_ok = entry_q.g || (entry_q.asid == asid_i);

    // both search ports compare in parallel
    assign hit0_o = entry_q.exist && asid_ok && (entry_q.vppn == s0_vppn_i);
    assign hit1_o = entry_q.exist && asid_ok && (entry_q.vppn == s1_vppn_i);

    assign entry_o = entry_q;

endmodule

`default_nettype wire

/* tlb/tlb_fill.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module tlb_fill (
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,
    input  wire logic                      we_i,
    input  wire logic [`MMU_TLB_IDX_W-1:0] widx_i,
    input  wire logic                      invall_i,
    output logic [`MMU_TLB_NUM-1:0]        we_vec_o,
    output logic                           invall_o
);

    // invalidate suppresses any write in the same cycle
    always_comb begin
        we_vec_o = '0;
        if (we_i && !invall_i) begin
            we_vec_o[widx_i] = 1'b1;
        end
    end

    assign invall_o = invall_i;

    // an unknown index would drop the write silently
    a_widx_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        we_i |-> !$isunknown(widx_i));

    a_strobe_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown({we_i, invall_i}));

endmodule

`default_nettype wire

/* tlb/tlb_lookup.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module tlb_lookup (
    input  wire logic [`MMU_TLB_NUM-1:0] hit0_i,
    input  wire logic [`MMU_TLB_NUM-1:0] hit1_i,
    input  wire mmu_pkg::tlb_entry_t     entries_i [`MMU_TLB_NUM],
    input  wire logic                    s0_odd_i,
    input  wire logic                    s1_odd_i,
    output mmu_pkg::tlb_search_t         s0_o,
    output mmu_pkg::tlb_search_t         s1_o
);

    logic [`MMU_TLB_IDX_W-1:0] idx0;
    logic [`MMU_TLB_IDX_W-1:0] idx1;
    mmu_pkg::tlb_entry_t       sel0;
    mmu_pkg::tlb_entry_t       sel1;

    // lowest index wins on multiple hits
    function automatic logic [`MMU_TLB_IDX_W-1:0] first_hit(
        input logic [`MMU_TLB_NUM-1:0] hit
    );
        logic [`MMU_TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `MMU_TLB_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                idx = `MMU_TLB_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign idx0 = first_hit(hit0_i);
    assign idx1 = first_hit(hit1_i);
    assign sel0 = entries_i[idx0];
    assign sel1 = entries_i[idx1];

    // va bit 12 picks odd or even half
    assign s0_o = '{found: |hit0_i, page: (s0_odd_i ? sel0.page1 : sel0.page0)};
    assign s1_o = '{found: |hit1_i, page: (s1_odd_i ? sel1.page1 : sel1.page0)};

    // a reported hit must come from a live entry
    a_s0_exist: assert final (!s0_o.found || sel0.exist);
    a_s1_exist: assert final (!s1_o.found || sel1.exist);

endmodule

`default_nettype wire

/* hdl/mmu_xlate.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module mmu_xlate (
    input  wire mmu_pkg::crmd_t       crmd_i,
    input  wire mmu_pkg::dmw_t        dmw0_i,
    input  wire mmu_pkg::dmw_t        dmw1_i,
    input  wire mmu_pkg::xlate_req_t  inst_req_i,
    input  wire mmu_pkg::xlate_req_t  data_req_i,
    input  wire mmu_pkg::tlb_search_t s0_i,
    input  wire mmu_pkg::tlb_search_t s1_i,
    output logic [18:0]               s0_vppn_o,
    output logic [18:0]               s1_vppn_o,
    output logic                      s0_odd_o,
    output logic                      s1_odd_o,
    output mmu_pkg::xlate_rsp_t       inst_rsp_o,
    output mmu_pkg::xlate_rsp_t       data_rsp_o
);

    logic [31:0] inst_va, data_va;
    logic        direct;
    logic        inst_win0, inst_win1, data_win0, data_win1;
    logic        inst_tlb, data_tlb;
    logic        inst_tlbr, inst_pif, inst_ppi;
    logic        data_tlbr, data_pil, data_pis, data_pme, data_ppi;

    // segment match and mask bit at the current level
    function automatic logic win_hit(
        input mmu_pkg::dmw_t dmw,
        input logic [31:0]   va,
        input logic [1:0]    plv
    );
        return (va[31:29] == dmw.vseg) && dmw.plv_en[plv];
    endfunction

    assign inst_va = inst_req_i.vaddr;
    assign data_va = data_req_i.vaddr;
    assign direct  = crmd_i.da && !crmd_i.pg;

    assign inst_win0 = win_hit(dmw0_i, inst_va, crmd_i.plv);
    assign inst_win1 = win_hit(dmw1_i, inst_va, crmd_i.plv);
    assign data_win0 = win_hit(dmw0_i, data_va, crmd_i.plv);
    assign data_win1 = win_hit(dmw1_i, data_va, crmd_i.plv);

    assign inst_tlb = !direct && !inst_win0 && !inst_win1;
    assign data_tlb = !direct && !data_win0 && !data_win1;

    //////////////////////////////////////////////////
    // tlb search keys
    //////////////////////////////////////////////////

    assign s0_vppn_o = inst_va[31:13];
    assign s0_odd_o  = inst_va[12];
    assign s1_vppn_o = data_va[31:13];
    assign s1_odd_o  = data_va[12];

    //////////////////////////////////////////////////
    // exceptions in tlb mode
    //////////////////////////////////////////////////

    assign inst_tlbr = inst_tlb && !s0_i.found;
    assign inst_pif  = inst_tlb && s0_i.found && !s0_i.page.v;
    assign inst_ppi  = inst_tlb && s0_i.found && s0_i.page.v && (crmd_i.plv > s0_i.page.plv);

    assign data_tlbr = data_tlb && !s1_i.found;
    assign data_pil  = data_tlb && s1_i.found && !s1_i.page.v && !data_req_i.wr;
    assign data_pis  = data_tlb && s1_i.found && !s1_i.page.v && data_req_i.wr;
    // store to a clean page that the level may access
    assign data_pme  = data_tlb && s1_i.found && s1_i.page.v && (crmd_i.plv <= s1_i.page.plv)
                       && data_req_i.wr && !s1_i.page.d;
    assign data_ppi  = data_tlb && s1_i.found && s1_i.page.v && (crmd_i.plv > s1_i.page.plv);

    assign inst_rsp_o.paddr = direct    ? inst_va :
                              inst_win0 ? {dmw0_i.pseg, inst_va[28:0]} :
                              inst_win1 ? {dmw1_i.pseg, inst_va[28:0]} :
                                          {s0_i.page.ppn, inst_va[11:0]};
    assign inst_rsp_o.ecode = inst_tlbr ? `MMU_ECODE_TLBR :
                              inst_pif  ? `MMU_ECODE_PIF :
                              inst_ppi  ? `MMU_ECODE_PPI : `MMU_ECODE_NONE;
    assign inst_rsp_o.esubcode = 9'h0;

    assign data_rsp_o.paddr = direct    ? data_va :
                              data_win0 ? {dmw0_i.pseg, data_va[28:0]} :
                              data_win1 ? {dmw1_i.pseg, data_va[28:0]} :
                                          {s1_i.page.ppn, data_va[11:0]};
    assign data_rsp_o.ecode = data_tlbr ? `MMU_ECODE_TLBR :
                              data_pil  ? `MMU_ECODE_PIL :
                              data_pis  ? `MMU_ECODE_PIS :
                              data_pme  ? `MMU_ECODE_PME :
                              data_ppi  ? `MMU_ECODE_PPI : `MMU_ECODE_NONE;
    assign data_rsp_o.esubcode = 9'h0;

endmodule

`default_nettype wire

/* hdl/mmu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module mmu_top (
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,
    input  wire mmu_pkg::crmd_t            crmd_i,
    input  wire mmu_pkg::dmw_t             dmw0_i,
    input  wire mmu_pkg::dmw_t             dmw1_i,
    input  wire logic [9:0]                asid_i,
    input  wire logic                      tlb_we_i,
    input  wire logic [`MMU_TLB_IDX_W-1:0] tlb_widx_i,
    input  wire mmu_pkg::tlb_entry_t       tlb_wentry_i,
    input  wire logic                      tlb_invall_i,
    input  wire mmu_pkg::xlate_req_t       inst_req_i,
    input  wire mmu_pkg::xlate_req_t       data_req_i,
    output mmu_pkg::xlate_rsp_t            inst_rsp_o,
    output mmu_pkg::xlate_rsp_t            data_rsp_o
);

    logic [`MMU_TLB_NUM-1:0] we_vec;
    logic                    invall;
    logic [`MMU_TLB_NUM-1:0] hit0, hit1;
    mmu_pkg::tlb_entry_t     entries [`MMU_TLB_NUM];
    logic [18:0]             s0_vppn, s1_vppn;
    logic                    s0_odd, s1_odd;
    mmu_pkg::tlb_search_t    s0, s1;

    //////////////////////////////////////////////////
    // tlb write path
    //////////////////////////////////////////////////

    tlb_fill u_fill (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (tlb_we_i),
        .widx_i   (tlb_widx_i),
        .invall_i (tlb_invall_i),
        .we_vec_o (we_vec),
        .invall_o (invall)
    );

    for (genvar i = 0; i < `MMU_TLB_NUM; i++) begin : g_entry
        tlb_entry u_entry (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .we_i      (we_vec[i]),
            .invall_i  (invall),
            .wentry_i  (tlb_wentry_i),
            .s0_vppn_i (s0_vppn),
            .s1_vppn_i (s1_vppn),
            .asid_i    (asid_i),
            .hit0_o    (hit0[i]),
            .hit1_o    (hit1[i]),
            .entry_o   (entries[i])
        );
    end

    //////////////////////////////////////////////////
    // search and translate
    //////////////////////////////////////////////////

    tlb_lookup u_lookup (
        .hit0_i    (hit0),
        .hit1_i    (hit1),
        .entries_i (entries),
        .s0_odd_i  (s0_odd),
        .s1_odd_i  (s1_odd),
        .s0_o      (s0),
        .s1_o      (s1)
    );

    mmu_xlate u_xlate (
        .crmd_i     (crmd_i),
        .dmw0_i     (dmw0_i),
        .dmw1_i     (dmw1_i),
        .inst_req_i (inst_req_i),
        .data_req_i (data_req_i),
        .s0_i       (s0),
        .s1_i       (s1),
        .s0_vppn_o  (s0_vppn),
        .s1_vppn_o  (s1_vppn),
        .s0_odd_o   (s0_odd),
        .s1_odd_o   (s1_odd),
        .inst_rsp_o (inst_rsp_o),
        .data_rsp_o (data_rsp_o)
    );

endmodule

`default_nettype wire

/* verif/mmu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mmu_defines.svh"

module mmu_tb;

    // the tests take roughly 700 cycles
    localparam int MAX_CYCLES = 2000;

    logic                      clk = 1'b0;
    logic                      arst_n;
    mmu_pkg::crmd_t            crmd;
    mmu_pkg::dmw_t             dmw0, dmw1;
    logic [9:0]                asid;
    logic                      tlb_we, tlb_invall;
    logic [`MMU_TLB_IDX_W-1:0] tlb_widx;
    mmu_pkg::tlb_entry_t       tlb_wentry;
    mmu_pkg::xlate_req_t       inst_req, data_req;
    mmu_pkg::xlate_rsp_t       inst_rsp, data_rsp;

    // reference copy of the tlb and the expected responses
    mmu_pkg::tlb_entry_t       ref_tlb [`MMU_TLB_NUM];
    mmu_pkg::xlate_rsp_t       exp_inst, exp_data;
    logic                      check_en = 1'b0;
    logic [15:0]               lfsr_q;
    logic [31:0]               va;
    int                        cycle_cnt = 0;
    int                        check_cnt = 0;
    int                        mismatch_cnt = 0;
    int                        test_start = 0;
    int                        pass_tests = 0;
    int                        fail_tests = 0;

    mmu_top dut_i (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .crmd_i       (crmd),
        .dmw0_i       (dmw0),
        .dmw1_i       (dmw1),
        .asid_i       (asid),
        .tlb_we_i     (tlb_we),
        .tlb_widx_i   (tlb_widx),
        .tlb_wentry_i (tlb_wentry),
        .tlb_invall_i (tlb_invall),
        .inst_req_i   (inst_req),
        .data_req_i   (data_req),
        .inst_rsp_o   (inst_rsp),
        .data_rsp_o   (data_rsp)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // random source and reference model
    //////////////////////////////////////////////////

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b = lfsr_q[0];
            lfsr_q = {1'b0, lfsr_q[15:1]} ^ (b ? 16'hB400 : 16'h0000);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic mmu_pkg::xlate_rsp_t ref_xlate(input mmu_pkg::xlate_req_t req,
                                                      input logic is_data);
        mmu_pkg::xlate_rsp_t rsp;
        mmu_pkg::tlb_page_t  page;
        logic                found;
        rsp = '0;
        page = '0;
        found = 1'b0;
        if (crmd.da && !crmd.pg) begin
            rsp.paddr = req.vaddr;
        end else if (req.vaddr[31:29] == dmw0.vseg && dmw0.plv_en[crmd.plv]) begin
            rsp.paddr = {dmw0.pseg, req.vaddr[28:0]};
        end else if (req.vaddr[31:29] == dmw1.vseg && dmw1.plv_en[crmd.plv]) begin
            rsp.paddr = {dmw1.pseg, req.vaddr[28:0]};
        end else begin
            // first matching entry in index order
            for (int i = 0; i < `MMU_TLB_NUM; i++) begin
                if (!found && ref_tlb[i].exist && ref_tlb[i].vppn == req.vaddr[31:13]
                    && (ref_tlb[i].g || ref_tlb[i].asid == asid)) begin
                    found = 1'b1;
                    page = req.vaddr[12] ? ref_tlb[i].page1 : ref_tlb[i].page0;
                end
            end
            rsp.paddr = {page.ppn, req.vaddr[11:0]};
            if (!found) rsp.ecode = `MMU_ECODE_TLBR;
            else if (!page.v && !is_data) rsp.ecode = `MMU_ECODE_PIF;
            else if (!page.v && !req.wr) rsp.ecode = `MMU_ECODE_PIL;
            else if (!page.v) rsp.ecode = `MMU_ECODE_PIS;
            else if (is_data && req.wr && !page.d && crmd.plv <= page.plv)
                rsp.ecode = `MMU_ECODE_PME;
            else if (crmd.plv > page.plv) rsp.ecode = `MMU_ECODE_PPI;
        end
        return rsp;
    endfunction

    //////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////

    task automatic compare_rsp(input string name, input mmu_pkg::xlate_rsp_t expv,
                               input mmu_pkg::xlate_rsp_t actv);
        check_cnt++;
        if (actv.ecode !== expv.ecode) begin
            $display("MISMATCH t=%0t %s.ecode expected %h actual %h",
                     $time, name, expv.ecode, actv.ecode);
            mismatch_cnt++;
        end
        // paddr carries no meaning on a refill
        if (expv.ecode != `MMU_ECODE_TLBR && actv.paddr !== expv.paddr) begin
            $display("MISMATCH t=%0t %s.paddr expected %h actual %h",
                     $time, name, expv.paddr, actv.paddr);
            mismatch_cnt++;
        end
        if (actv.esubcode !== expv.esubcode) begin
            $display("MISMATCH t=%0t %s.esubcode expected %h actual %h",
                     $time, name, expv.esubcode, actv.esubcode);
            mismatch_cnt++;
        end
    endtask

    // sample just before the rising edge
    always @(negedge clk) begin
        #9;
        if (check_en) begin
            compare_rsp("inst_rsp_o", exp_inst, inst_rsp);
            compare_rsp("data_rsp_o", exp_data, data_rsp);
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    // inputs were set at the falling edge and the tlb copy follows the rising edge
    task automatic run_cycle();
        exp_inst = ref_xlate(inst_req, 1'b0);
        exp_data = ref_xlate(data_req, 1'b1);
        check_en = 1'b1;
        @(posedge clk);
        if (tlb_invall) begin
            for (int i = 0; i < `MMU_TLB_NUM; i++) ref_tlb[i].exist = 1'b0;
        end else if (tlb_we) begin
            ref_tlb[tlb_widx] = tlb_wentry;
        end
        @(negedge clk);
        check_en = 1'b0;
        tlb_we = 1'b0;
        tlb_invall = 1'b0;
    endtask

    task automatic set_mode(input logic [1:0] plv, input logic da, input logic pg);
        crmd.plv = plv;
        crmd.da = da;
        crmd.pg = pg;
    endtask

    task automatic set_reqs(input logic [31:0] iva, input logic [31:0] dva);
        inst_req.vaddr = iva;
        inst_req.wr = rand_bits(1);
        data_req.vaddr = dva;
        data_req.wr = rand_bits(1);
    endtask

    function automatic logic [31:0] addr_in(input int idx);
        return {ref_tlb[idx].vppn, 13'(rand_bits(13))};
    endfunction

    // top segment from a window or random
    function automatic logic [31:0] seg_addr();
        logic [1:0] sel;
        logic [2:0] seg;
        sel = 2'(rand_bits(2));
        seg = (sel == 2'd0) ? dmw0.vseg : (sel == 2'd1) ? dmw1.vseg : 3'(rand_bits(3));
        return {seg, 29'(rand_bits(29))};
    endfunction

    function automatic mmu_pkg::tlb_page_t make_page(input logic v, input logic d,
                                                     input logic [1:0] plv);
        mmu_pkg::tlb_page_t p;
        p.ppn = 20'(rand_bits(20));
        p.plv = plv;
        p.mat = 2'(rand_bits(2));
        p.d = d;
        p.v = v;
        return p;
    endfunction

    task automatic write_entry(input int idx, input logic [18:0] vppn, input logic g,
                               input logic [9:0] easid, input logic v, input logic d,
                               input logic [1:0] plv);
        tlb_we = 1'b1;
        tlb_widx = `MMU_TLB_IDX_W'(idx);
        tlb_wentry.exist = 1'b1;
        tlb_wentry.vppn = vppn;
        tlb_wentry.asid = easid;
        tlb_wentry.g = g;
        tlb_wentry.page0 = make_page(v, d, plv);
        tlb_wentry.page1 = make_page(v, d, plv);
    endtask

    task automatic end_test(input string name);
        if (mismatch_cnt == test_start) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d mismatches", name, mismatch_cnt - test_start);
        end
        test_start = mismatch_cnt;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        lfsr_q = 16'd57803;
        arst_n = 1'b0;
        set_mode(2'd0, 1'b0, 1'b1);
        dmw0 = '0;
        dmw1 = '0;
        asid = '0;
        tlb_we = 1'b0;
        tlb_invall = 1'b0;
        tlb_widx = '0;
        tlb_wentry = '0;
        inst_req = '0;
        data_req = '0;
        for (int i = 0; i < `MMU_TLB_NUM; i++) ref_tlb[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // empty tlb refills and direct mode passes through
        for (int n = 0; n < 50; n++) begin
            set_mode(2'(rand_bits(2)), 1'b0, 1'b1);
            // odd steps use page pair 0 which cleared entries would match
            if (n[0]) begin
                set_reqs(addr_in(rand_bits(4)), addr_in(rand_bits(4)));
            end else begin
                set_reqs(rand_bits(32), rand_bits(32));
            end
            run_cycle();
        end
        for (int n = 0; n < 50; n++) begin
            set_mode(2'(rand_bits(2)), 1'b1, 1'b0);
            dmw0 = 12'(rand_bits(12));
            dmw1 = 12'(rand_bits(12));
            set_reqs(rand_bits(32), rand_bits(32));
            run_cycle();
        end
        end_test("after reset");

        for (int n = 0; n < 200; n++) begin
            set_mode(2'(rand_bits(2)), 1'b0, 1'b1);
            dmw0 = 12'(rand_bits(12));
            dmw1 = 12'(rand_bits(12));
            if (rand_bits(1)) dmw1.vseg = dmw0.vseg;
            set_reqs(seg_addr(), seg_addr());
            run_cycle();
        end
        dmw0 = '0;
        dmw1 = '0;
        end_test("mapping windows");

        set_mode(2'd0, 1'b0, 1'b1);
        asid = 10'h055;
        for (int i = 0; i < `MMU_TLB_NUM; i++) begin
            write_entry(i, 19'(rand_bits(19)), rand_bits(1),
                        rand_bits(1) ? 10'h055 : 10'h2AA, 1'b1, 1'b1, 2'd3);
            va = {tlb_wentry.vppn, 13'(rand_bits(13))};
            set_reqs(va, va);
            run_cycle();
            set_reqs(va, va);
            run_cycle();
        end
        for (int n = 0; n < 150; n++) begin
            set_mode(2'(rand_bits(2)), 1'b0, 1'b1);
            asid = rand_bits(1) ? 10'h055 : 10'h2AA;
            set_reqs(addr_in(rand_bits(4)), addr_in(rand_bits(4)));
            run_cycle();
        end
        // two entries on one page where the lowest index wins
        write_entry(3, 19'h1_2345, 1'b1, 10'h2AA, 1'b1, 1'b1, 2'd3);
        run_cycle();
        write_entry(9, 19'h1_2345, 1'b1, 10'h2AA, 1'b1, 1'b1, 2'd3);
        run_cycle();
        write_entry(3, 19'h1_2345, 1'b0, 10'h2AA, 1'b1, 1'b1, 2'd3);
        run_cycle();
        for (int n = 0; n < 8; n++) begin
            asid = n[0] ? 10'h055 : 10'h2AA;
            va = {19'h1_2345, 13'(rand_bits(13))};
            set_reqs(va, va);
            run_cycle();
        end
        end_test("tlb hits");

        set_mode(2'd0, 1'b0, 1'b1);
        for (int k = 0; k < 16; k++) begin
            write_entry(0, 19'h4_1234, 1'b1, 10'h000, k[3], k[2], k[1:0]);
            run_cycle();
            for (int m = 0; m < 8; m++) begin
                set_mode(m[1:0], 1'b0, 1'b1);
                va = {19'h4_1234, 13'(rand_bits(13))};
                inst_req.vaddr = va;
                inst_req.wr = 1'b0;
                data_req.vaddr = va;
                data_req.wr = m[2];
                run_cycle();
            end
        end
        end_test("exception codes");

        set_mode(2'd0, 1'b0, 1'b1);
        tlb_invall = 1'b1;
        run_cycle();
        for (int n = 0; n < 40; n++) begin
            set_reqs(addr_in(rand_bits(4)), addr_in(rand_bits(4)));
            run_cycle();
        end
        write_entry(5, 19'h0_7777, 1'b1, 10'h000, 1'b1, 1'b1, 2'd3);
        tlb_invall = 1'b1;
        va = {19'h0_7777, 13'(rand_bits(13))};
        set_reqs(va, va);
        run_cycle();
        repeat (2) begin
            set_reqs(va, va);
            run_cycle();
        end
        end_test("invalidate");

        $display("tests passed %0d failed %0d, %0d checks, %0d mismatches",
                 pass_tests, fail_tests, check_cnt, mismatch_cnt);
        if (fail_tests == 0 && mismatch_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mmu_top.f */
+incdir+common
common/mmu_pkg.sv
tlb/tlb_entry.sv
tlb/tlb_fill.sv
tlb/tlb_lookup.sv
hdl/mmu_xlate.sv
hdl/mmu_top.sv
verif/mmu_tb.sv

/* Bender.yml */
package:
  name: mmu_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mmu_pkg.sv
      - tlb/tlb_entry.sv
      - tlb/tlb_fill.sv
      - tlb/tlb_lookup.sv
      - hdl/mmu_xlate.sv
      - hdl/mmu_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - verif/mmu_tb.sv
